// File: design/eq_settings.svh
// Width and channel-count macros for the three-band equalizer
`ifndef EQ_SETTINGS_SVH
`define EQ_SETTINGS_SVH

// Signed audio sample width
`define EQ_SAMPLE_W  16

// Coefficient fraction bits
// Q2.14, so 16384 is unity gain
`define EQ_COEF_FRAC 14

// MAC accumulator width
// Five 32-bit products summed cannot reach the top bit
`define EQ_ACC_W     40

// Interleaved channels on one word clock, left then right
`define EQ_CHANNELS  2

`endif

// File: design/eq_pkg.sv
// Package with the sample, coefficient and accumulator types of the equalizer
`include "eq_settings.svh"

package eq_pkg;

    // Signed PCM sample, also the width of every band result
    typedef logic signed [`EQ_SAMPLE_W-1:0] sample_t;

    // Signed Q2.14 filter coefficient
    // Two integer bits, so the range is -2.0 up to just under 2.0
    typedef logic signed [`EQ_COEF_FRAC+1:0] coef_t;

    // Signed accumulator of the biquad MAC
    typedef logic signed [`EQ_ACC_W-1:0] acc_t;

endpackage

// File: design/lrclk_edge_decode.sv
// Word-clock synchronizer, edge detector and input sample/channel latch
`timescale 1ns/1ps

module lrclk_edge_decode
    import eq_pkg::*;
(
    input  logic    clk,
    input  logic    reset,          // Synchronous, active low
    input  logic    l_r_clk,        // Word clock, low is left, high is right
    input  sample_t audio_in,       // Parallel sample, held a few cycles past the edge
    output logic    sample_strobe,  // One pulse per word-clock edge
    output sample_t sample,         // Sample latched with the strobe
    output logic    channel         // Channel of that sample
);

    logic lr_meta;      // First synchronizer stage
    logic lr_sync;      // Second synchronizer stage, safe to use
    logic lr_prev;      // Synchronized level one cycle back
    logic edge_seen;    // Level change seen, strobe goes out next cycle

    // Sync chain and edge pipeline
    always_ff @(posedge clk) begin
        if (!reset) begin
            // Whole chain follows the pin so leaving reset makes no edge
            lr_meta       <= l_r_clk;
            lr_sync       <= l_r_clk;
            lr_prev       <= l_r_clk;
            edge_seen     <= 1'b0;
            sample_strobe <= 1'b0;
            channel       <= 1'b0;
        end else begin
            lr_meta       <= l_r_clk;
            lr_sync       <= lr_meta;
            lr_prev       <= lr_sync;
            edge_seen     <= (lr_sync != lr_prev);  // Either edge direction
            sample_strobe <= edge_seen;             // Three cycles after first capture
            if (edge_seen) begin
                channel <= lr_prev;                 // New level picks the channel
            end
        end
    end

    // Capture the word on the strobe cycle
    always_ff @(posedge clk) begin
        if (edge_seen) begin
            sample <= audio_in;
        end
    end

endmodule

// File: design/biquad_mac.sv
// Direct-form-I biquad sequenced over one multiplier with per-channel history
`timescale 1ns/1ps
`include "eq_settings.svh"

module biquad_mac
    import eq_pkg::*;
(
    input  logic    clk,
    input  logic    reset,      // Synchronous, active low
    input  logic    start,      // New sample ready, ignored while busy
    input  logic    channel,    // Channel of the new sample
    input  sample_t sample,     // x0
    input  coef_t   b0,
    input  coef_t   b1,
    input  coef_t   b2,
    input  coef_t   a1,         // Feedback terms, subtracted
    input  coef_t   a2,
    output logic    done,       // One-cycle pulse when result updates
    output sample_t result      // Rounded, saturated y0
);

    localparam logic [2:0] PHASE_LAST = 3'd5;  // Round/saturate step
    localparam int         PROD_W     = `EQ_SAMPLE_W + `EQ_COEF_FRAC + 2;

    localparam acc_t ROUND_HALF = acc_t'(2 ** (`EQ_COEF_FRAC - 1));  // 0.5 LSB
    localparam acc_t SAT_MAX    = acc_t'(2 ** (`EQ_SAMPLE_W - 1) - 1);
    localparam acc_t SAT_MIN    = acc_t'(-(2 ** (`EQ_SAMPLE_W - 1)));

    logic                     busy;
    logic [2:0]               phase;        // 0 on start, 1..4 accumulate, 5 finish
    logic                     ch_r;         // Channel in flight, picks the history bank
    sample_t                  x0_r;         // Sample in flight, becomes x1
    acc_t                     acc;
    coef_t                    mul_coef;
    sample_t                  mul_data;
    logic                     mul_sub;      // Feedback product is subtracted
    logic signed [PROD_W-1:0] product;
    acc_t                     product_ext;
    acc_t                     mac_term;
    acc_t                     acc_rounded;
    acc_t                     acc_shifted;
    sample_t                  result_sat;

    // One history bank per channel
    sample_t x1_hist [`EQ_CHANNELS];
    sample_t x2_hist [`EQ_CHANNELS];
    sample_t y1_hist [`EQ_CHANNELS];
    sample_t y2_hist [`EQ_CHANNELS];

    // Coefficient/operand select by phase
    always_comb begin
        mul_coef = b0;
        mul_data = sample;      // Phase 0, fresh x0
        mul_sub  = 1'b0;
        case (phase)
            3'd1: begin
                mul_coef = b1;
                mul_data = x1_hist[ch_r];
            end
            3'd2: begin
                mul_coef = b2;
                mul_data = x2_hist[ch_r];
            end
            3'd3: begin
                mul_coef = a1;
                mul_data = y1_hist[ch_r];
                mul_sub  = 1'b1;
            end
            3'd4: begin
                mul_coef = a2;
                mul_data = y2_hist[ch_r];
                mul_sub  = 1'b1;
            end
            default: begin
                mul_coef = b0;
                mul_data = sample;
            end
        endcase
    end

    assign product     = mul_coef * mul_data;           // Q2.14 x Q15
    assign product_ext = acc_t'(product);               // Sign-extend to acc
    assign mac_term    = mul_sub ? -product_ext : product_ext;

    // Round half up, drop fraction bits, clamp to 16 bits
    assign acc_rounded = acc + ROUND_HALF;
    assign acc_shifted = acc_rounded >>> `EQ_COEF_FRAC;

    always_comb begin
        if (acc_shifted > SAT_MAX) begin
            result_sat = SAT_MAX[`EQ_SAMPLE_W-1:0];
        end else if (acc_shifted < SAT_MIN) begin
            result_sat = SAT_MIN[`EQ_SAMPLE_W-1:0];
        end else begin
            result_sat = acc_shifted[`EQ_SAMPLE_W-1:0];
        end
    end

    // Sequencer, output and history
    always_ff @(posedge clk) begin
        if (!reset) begin
            busy   <= 1'b0;
            phase  <= 3'd0;
            ch_r   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
            for (int c = 0; c < `EQ_CHANNELS; c++) begin
                x1_hist[c] <= '0;
                x2_hist[c] <= '0;
                y1_hist[c] <= '0;
                y2_hist[c] <= '0;
            end
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy  <= 1'b1;
                    phase <= 3'd1;      // b0 term already taken this cycle
                    ch_r  <= channel;
                end
            end else if (phase == PHASE_LAST) begin
                busy   <= 1'b0;
                phase  <= 3'd0;
                done   <= 1'b1;
                result <= result_sat;
                x2_hist[ch_r] <= x1_hist[ch_r];  // Shift this channel's delay line
                x1_hist[ch_r] <= x0_r;
                y2_hist[ch_r] <= y1_hist[ch_r];
                y1_hist[ch_r] <= result_sat;     // Saturated value feeds back
            end else begin
                phase <= phase + 3'd1;
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            acc  <= mac_term;                   // Fresh sum from b0*x0
            x0_r <= sample;
        end else if (busy && (phase != PHASE_LAST)) begin
            acc <= acc + mac_term;
        end
    end

endmodule

// File: design/band_mixer.sv
// Band summer with 16-bit saturation, bypass select and output strobe
`timescale 1ns/1ps
`include "eq_settings.svh"

module band_mixer
    import eq_pkg::*;
(
    input  logic    clk,
    input  logic    reset,          // Synchronous, active low
    input  logic    band_done,      // All bands finished this cycle
    input  logic    channel,        // Channel of the finished sample
    input  logic    bypass,         // Pass dry sample through
    input  sample_t dry_sample,     // Unfiltered input, same latency path
    input  sample_t low_band,
    input  sample_t mid_band,
    input  sample_t high_band,
    output sample_t audio_out,
    output logic    out_channel,
    output logic    out_valid       // One pulse per output sample
);

    localparam int SUM_W = `EQ_SAMPLE_W + 2;   // Three bands need two extra bits

    localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'(2 ** (`EQ_SAMPLE_W - 1) - 1);
    localparam logic signed [SUM_W-1:0] SUM_MIN = SUM_W'(-(2 ** (`EQ_SAMPLE_W - 1)));

    logic signed [SUM_W-1:0] band_sum;
    sample_t                 sum_sat;

    // Widen before the add so the sum cannot wrap
    assign band_sum = SUM_W'(low_band) + SUM_W'(mid_band) + SUM_W'(high_band);

    always_comb begin
        if (band_sum > SUM_MAX) begin
            sum_sat = SUM_MAX[`EQ_SAMPLE_W-1:0];   // Clip to 0x7fff
        end else if (band_sum < SUM_MIN) begin
            sum_sat = SUM_MIN[`EQ_SAMPLE_W-1:0];   // Clip to 0x8000
        end else begin
            sum_sat = band_sum[`EQ_SAMPLE_W-1:0];
        end
    end

    // Output register, one cycle after the bands finish
    always_ff @(posedge clk) begin
        if (!reset) begin
            audio_out   <= '0;
            out_channel <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            out_valid <= band_done;
            if (band_done) begin
                audio_out   <= bypass ? dry_sample : sum_sat;
                out_channel <= channel;
            end
        end
    end

endmodule

// File: design/three_band_eq.sv
// Top level of the stereo three-band equalizer with decoder, three biquads and mixer
`timescale 1ns/1ps

module three_band_eq
    import eq_pkg::*;
(
    input  logic    clk,
    input  logic    reset,          // Synchronous, active low
    input  logic    l_r_clk,        // Word clock, one sample per edge
    input  logic    filter_bypass,
    input  sample_t audio_in,
    input  coef_t   low_b0,         // Low band, Q2.14
    input  coef_t   low_b1,
    input  coef_t   low_b2,
    input  coef_t   low_a1,
    input  coef_t   low_a2,
    input  coef_t   mid_b0,         // Mid band
    input  coef_t   mid_b1,
    input  coef_t   mid_b2,
    input  coef_t   mid_a1,
    input  coef_t   mid_a2,
    input  coef_t   high_b0,        // High band
    input  coef_t   high_b1,
    input  coef_t   high_b2,
    input  coef_t   high_a1,
    input  coef_t   high_a2,
    output sample_t audio_out,
    output logic    out_channel,    // 0 left, 1 right
    output logic    out_valid
);

    logic    sample_strobe;
    sample_t sample;
    logic    channel;
    sample_t low_band_out;
    sample_t mid_band_out;
    sample_t high_band_out;
    logic    low_done;              // Bands run in lockstep, low done stands for all

    lrclk_edge_decode decode_i (
        .clk           (clk),
        .reset         (reset),
        .l_r_clk       (l_r_clk),
        .audio_in      (audio_in),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .channel       (channel)
    );

    // All three bands see the same input in parallel
    biquad_mac low_band_filter (
        .clk (clk), .reset (reset), .start (sample_strobe), .channel (channel),
        .sample (sample),
        .b0 (low_b0), .b1 (low_b1), .b2 (low_b2), .a1 (low_a1), .a2 (low_a2),
        .done (low_done), .result (low_band_out)
    );

    biquad_mac mid_band_filter (
        .clk (clk), .reset (reset), .start (sample_strobe), .channel (channel),
        .sample (sample),
        .b0 (mid_b0), .b1 (mid_b1), .b2 (mid_b2), .a1 (mid_a1), .a2 (mid_a2),
        .done (), .result (mid_band_out)
    );

    biquad_mac high_band_filter (
        .clk (clk), .reset (reset), .start (sample_strobe), .channel (channel),
        .sample (sample),
        .b0 (high_b0), .b1 (high_b1), .b2 (high_b2), .a1 (high_a1), .a2 (high_a2),
        .done (), .result (high_band_out)
    );

    band_mixer mixer_i (
        .clk         (clk),
        .reset       (reset),
        .band_done   (low_done),
        .channel     (channel),
        .bypass      (filter_bypass),
        .dry_sample  (sample),      // Held by the decoder until the next strobe
        .low_band    (low_band_out),
        .mid_band    (mid_band_out),
        .high_band   (high_band_out),
        .audio_out   (audio_out),
        .out_channel (out_channel),
        .out_valid   (out_valid)
    );

endmodule

// File: verif/three_band_eq_tb.sv
// Testbench for the three-band equalizer with clock, reset, filter model, directed tests and watchdog
`timescale 1ns/1ps

module three_band_eq_tb
    import eq_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 5;       // Inputs change this long after posedge
    localparam int RESET_CYCLES  = 16;
    localparam int HALF_PERIOD   = 16;      // Word-clock half period in clk cycles
    localparam int LATENCY       = 10;      // First edge seeing new level to out_valid
    localparam int ROUND_HALF    = 8192;
    localparam int FRAC_BITS     = 14;
    localparam int N_RANDOM      = 40;
    localparam int TOTAL_SAMPLES = 4 + 12 + 16 + 4 + N_RANDOM;
    localparam int WATCHDOG_CYC  = TOTAL_SAMPLES * 32 + 3 * RESET_CYCLES + 400;

    logic    clk;
    logic    reset;
    logic    l_r_clk;
    logic    filter_bypass;
    sample_t audio_in;
    sample_t audio_out;
    logic    out_channel;
    logic    out_valid;
    coef_t   coef [3][5];               // Band low/mid/high, then b0 b1 b2 a1 a2

    int x1_m [3][2];                    // Model history per band and channel
    int x2_m [3][2];
    int y1_m [3][2];
    int y2_m [3][2];
    int test_errors;
    int tests_ok;
    int tests_bad;
    int seed_ret;

    three_band_eq three_band_eq_i (
        .clk (clk), .reset (reset), .l_r_clk (l_r_clk), .filter_bypass (filter_bypass),
        .audio_in (audio_in),
        .low_b0 (coef[0][0]), .low_b1 (coef[0][1]), .low_b2 (coef[0][2]),
        .low_a1 (coef[0][3]), .low_a2 (coef[0][4]),
        .mid_b0 (coef[1][0]), .mid_b1 (coef[1][1]), .mid_b2 (coef[1][2]),
        .mid_a1 (coef[1][3]), .mid_a2 (coef[1][4]),
        .high_b0 (coef[2][0]), .high_b1 (coef[2][1]), .high_b2 (coef[2][2]),
        .high_a1 (coef[2][3]), .high_a2 (coef[2][4]),
        .audio_out (audio_out), .out_channel (out_channel), .out_valid (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Clamp to the signed 16-bit range
    function automatic int clamp16(input longint v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return int'(v);
    endfunction

    // Reference model of three parallel DF-I biquads summed into one output
    task automatic model_sample(input int x0, input bit ch, output int expected);
        longint acc;
        int     y;
        int     mix;
        mix = 0;
        for (int b = 0; b < 3; b++) begin
            acc = longint'(coef[b][0]) * x0 + longint'(coef[b][1]) * x1_m[b][ch]
                + longint'(coef[b][2]) * x2_m[b][ch] - longint'(coef[b][3]) * y1_m[b][ch]
                - longint'(coef[b][4]) * y2_m[b][ch];
            y = clamp16((acc + ROUND_HALF) >>> FRAC_BITS);  // Floor after half-LSB add
            x2_m[b][ch] = x1_m[b][ch];
            x1_m[b][ch] = x0;
            y2_m[b][ch] = y1_m[b][ch];
            y1_m[b][ch] = y;                                // Saturated value feeds back
            mix += y;
        end
        expected = filter_bypass ? x0 : clamp16(mix);       // Histories run under bypass too
    endtask

    task automatic clear_model();
        for (int b = 0; b < 3; b++) begin
            for (int c = 0; c < 2; c++) begin
                x1_m[b][c] = 0;
                x2_m[b][c] = 0;
                y1_m[b][c] = 0;
                y2_m[b][c] = 0;
            end
        end
    endtask

    task automatic set_band(input int b, input int b0, input int b1, input int b2,
                            input int a1, input int a2);
        coef[b][0] = coef_t'(b0);
        coef[b][1] = coef_t'(b1);
        coef[b][2] = coef_t'(b2);
        coef[b][3] = coef_t'(a1);
        coef[b][4] = coef_t'(a2);
    endtask

    // Outputs must stay quiet and zero while reset and right after it
    task automatic check_quiet();
        if (out_valid !== 1'b0) begin
            $display("error out_valid expected 0 got %h", out_valid);
            test_errors++;
        end
        if (audio_out !== 16'h0000) begin
            $display("error audio_out expected 0000 got %h", audio_out);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i > 0) begin
                check_quiet();          // First edge is where reset takes hold
            end
        end
        reset = 1'b1;
        clear_model();
        for (int i = 0; i < HALF_PERIOD; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_quiet();              // Leaving reset must not look like an edge
        end
    endtask

    // Toggle the word clock with a new sample and watch one half period for a single out_valid
    task automatic send_sample(input int x, output sample_t got);
        int expected;
        int valid_count;
        bit ch;
        got = '0;
        valid_count = 0;
        l_r_clk = ~l_r_clk;
        audio_in = sample_t'(x);
        ch = l_r_clk;                   // Low left, high right
        model_sample(x, ch, expected);
        for (int cyc = 1; cyc <= HALF_PERIOD; cyc++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (out_valid) begin
                valid_count++;
                got = audio_out;
                if (cyc != LATENCY + 1) begin   // Edge 1 is the first to see the level
                    $display("out_valid came %0d cycles after the edge, not %0d",
                             cyc - 1, LATENCY);
                    test_errors++;
                end
                if (audio_out !== sample_t'(expected)) begin
                    $display("error audio_out expected %h got %h",
                             sample_t'(expected), audio_out);
                    test_errors++;
                end
                if (out_channel !== ch) begin
                    $display("error out_channel expected %h got %h", ch, out_channel);
                    test_errors++;
                end
            end
        end
        if (valid_count == 0) begin
            $display("no out_valid followed the word clock edge");
            test_errors++;
        end else if (valid_count > 1) begin
            $display("%0d out_valid pulses followed one word clock edge", valid_count);
            test_errors++;
        end
    endtask

    task automatic send_pair(input int left, input int right,
                             output sample_t got_l, output sample_t got_r);
        send_sample(left, got_l);
        send_sample(right, got_r);
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_bad++;
        end
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        sample_t gl;
        sample_t gr;
        apply_reset();
        for (int i = 0; i < 2; i++) begin
            send_pair(int'(sample_t'($urandom())), int'(sample_t'($urandom())), gl, gr);
        end
        report_test("reset_state");
    endtask

    task automatic test_identity_bypass();
        sample_t gl;
        sample_t gr;
        set_band(0, 16384, 0, 0, 0, 0);         // Unity b0, mid and high stay silent
        for (int i = 0; i < 4; i++) begin
            send_pair(int'(sample_t'($urandom())), int'(sample_t'($urandom())), gl, gr);
        end
        filter_bypass = 1'b1;
        for (int b = 0; b < 3; b++) begin
            for (int k = 0; k < 5; k++) begin
                coef[b][k] = coef_t'($urandom());   // Arbitrary values that bypass ignores
            end
        end
        for (int i = 0; i < 2; i++) begin
            send_pair(int'(sample_t'($urandom())), int'(sample_t'($urandom())), gl, gr);
        end
        filter_bypass = 1'b0;
        report_test("identity_bypass");
    endtask

    task automatic test_impulse_response();
        sample_t gl;
        sample_t gr;
        apply_reset();
        set_band(0, 4096, 4096, 0, -12288, 2048);
        set_band(1, 8192, 0, -8192, -8192, 4096);
        set_band(2, 6000, -6000, 0, 4096, 0);
        for (int i = 0; i < 8; i++) begin
            send_pair((i == 0) ? 20000 : 0, 0, gl, gr);   // Impulse on left only
            if (gr !== 16'h0000) begin
                $display("error audio_out expected 0000 got %h", gr);
                test_errors++;
            end
        end
        report_test("impulse_response");
    endtask

    task automatic test_saturation();
        sample_t gl;
        sample_t gr;
        for (int b = 0; b < 3; b++) begin
            set_band(b, 16384, 0, 0, 0, 0);
        end
        for (int i = 0; i < 2; i++) begin
            send_pair((i == 0) ? 32767 : -32768, (i == 0) ? -32768 : 32767, gl, gr);
            if (gl !== ((i == 0) ? 16'h7fff : 16'h8000)) begin
                $display("error audio_out expected %h got %h",
                         (i == 0) ? 16'h7fff : 16'h8000, gl);
                test_errors++;
            end
        end
        report_test("saturation");
    endtask

    task automatic test_random_coefs();
        sample_t gl;
        sample_t gr;
        for (int b = 0; b < 3; b++) begin
            for (int k = 0; k < 5; k++) begin
                coef[b][k] = coef_t'(int'($urandom_range(16382)) - 8191);  // Below 0.5
            end
        end
        for (int i = 0; i < N_RANDOM / 2; i++) begin
            send_pair(int'(sample_t'($urandom())), int'(sample_t'($urandom())), gl, gr);
        end
        report_test("random_coefs");
    endtask

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        l_r_clk = 1'b1;                 // First toggle lands on left
        filter_bypass = 1'b0;
        audio_in = '0;
        for (int b = 0; b < 3; b++) begin
            set_band(b, 0, 0, 0, 0, 0);
        end
        test_errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        seed_ret = $urandom(32'haed1_b4a3);
        clear_model();
        test_reset_state();
        test_identity_bypass();
        test_impulse_response();
        test_saturation();
        test_random_coefs();
        $display("summary: %0d ok, %0d with errors", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/eq_pkg.sv
design/lrclk_edge_decode.sv
design/biquad_mac.sv
design/band_mixer.sv
design/three_band_eq.sv
verif/three_band_eq_tb.sv

// File: Bender.yml
package:
  name: three_band_eq

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/eq_pkg.sv
      - design/lrclk_edge_decode.sv
      - design/biquad_mac.sv
      - design/band_mixer.sv
      - design/three_band_eq.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/three_band_eq_tb.sv
